// ==== logic/lsu_config.svh ====
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

`default_nettype none

// Data memory depth, log2 of the word count
`define LSU_DMEM_ADDR_BITS 8

// RV32 major opcodes
`define LSU_OP_LOAD  7'b0000011
`define LSU_OP_STORE 7'b0100011

`default_nettype wire

`endif

// ==== logic/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  mask_t;

    // funct3 access width
    typedef enum logic [2:0]
    {
        WIDTH_BYTE   = 3'b000,
        WIDTH_HALF   = 3'b001,
        WIDTH_WORD   = 3'b010,
        WIDTH_BYTE_U = 3'b100,
        WIDTH_HALF_U = 3'b101
    } width_t;

    ////////////////////////////////////////
    // Instruction word layouts
    ////////////////////////////////////////

    typedef struct packed
    {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed
    {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } s_fmt_t;

    // Load and store views of the same word
    typedef union packed
    {
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } instr_u;

endpackage

`default_nettype wire

// ==== logic/mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_if import lsu_pkg::*; ();

    logic  en;
    logic  we;
    word_t addr;
    mask_t be;
    word_t wdata;
    word_t rdata;

    // Load/store side
    modport requester (output en, output we, output addr, output be, output wdata,
                       input rdata);

    // Memory side
    modport responder (input en, input we, input addr, input be, input wdata,
                       output rdata);

endinterface

`default_nettype wire

// ==== logic/address_gen.sv ====
`timescale 1ns/1ps
`include "lsu_config.svh"
`default_nettype none

module address_gen
    import lsu_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         valid,
    input  wire instr_u instr,
    input  wire word_t  rs1_value,
    input  wire word_t  rs2_value,
    output logic        op_valid,
    output logic        op_store,
    output width_t      op_width,
    output word_t       op_addr,
    output word_t       op_wdata
);
    logic   is_load;
    logic   is_store;
    word_t  offset;
    width_t access_width;

    assign is_load  = instr.i_fmt.opcode == `LSU_OP_LOAD;
    assign is_store = instr.s_fmt.opcode == `LSU_OP_STORE;

    // Immediate is split in S-type
    always_comb
    begin
        if (is_store)
        begin
            offset       = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
            access_width = width_t'(instr.s_fmt.funct3);
        end
        else
        begin
            offset       = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            access_width = width_t'(instr.i_fmt.funct3);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            op_valid <= 1'b0;
        else
            op_valid <= valid & (is_load | is_store);

        op_store <= is_store;
        op_width <= access_width;
        op_addr  <= rs1_value + offset;
        op_wdata <= rs2_value;
    end

endmodule

`default_nettype wire

// ==== logic/load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store_unit
    import lsu_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         op_valid,
    input  wire         op_store,
    input  wire width_t op_width,
    input  wire word_t  op_addr,
    input  wire word_t  op_wdata,
    mem_if.requester    mem,
    output logic        done,
    output logic        fault,
    output word_t       load_data
);
    mask_t       lane_mask;
    word_t       lane_wdata;
    logic        misaligned;
    logic        bad_width;
    logic        op_fault;

    logic        s1_valid;
    logic        s1_load;
    logic        s1_unsigned;
    logic [1:0]  s1_size;
    logic [1:0]  s1_offset;
    logic        s1_fault;

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;
    word_t       extended;

    ////////////////////////////////////////
    // Request
    ////////////////////////////////////////

    always_comb
    begin
        lane_mask  = 4'b0000;
        misaligned = 1'b0;
        bad_width  = 1'b0;
        case (op_width)
            WIDTH_BYTE, WIDTH_BYTE_U:
                lane_mask = mask_t'(4'b0001 << op_addr[1:0]);
            WIDTH_HALF, WIDTH_HALF_U:
            begin
                lane_mask  = op_addr[1] ? 4'b1100 : 4'b0011;
                misaligned = op_addr[0];
            end
            WIDTH_WORD:
            begin
                lane_mask  = 4'b1111;
                misaligned = |op_addr[1:0];
            end
            default:
                bad_width = 1'b1;
        endcase
        // No unsigned stores
        if (op_store && op_width[2])
            bad_width = 1'b1;
    end

    // Store data copied into every candidate lane
    always_comb
    begin
        case (op_width)
            WIDTH_BYTE: lane_wdata = {4{op_wdata[7:0]}};
            WIDTH_HALF: lane_wdata = {2{op_wdata[15:0]}};
            default:    lane_wdata = op_wdata;
        endcase
    end

    assign op_fault  = misaligned | bad_width;
    assign mem.en    = op_valid & ~op_fault;
    assign mem.we    = op_store;
    assign mem.addr  = {op_addr[31:2], 2'b00};
    assign mem.be    = lane_mask;
    assign mem.wdata = lane_wdata;

    ////////////////////////////////////////
    // Response pipeline
    ////////////////////////////////////////

    // Stage 1 runs alongside the memory read
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            s1_valid <= 1'b0;
        else
            s1_valid <= op_valid;

        s1_load     <= ~op_store;
        s1_unsigned <= op_width[2];
        s1_size     <= op_width[1:0];
        s1_offset   <= op_addr[1:0];
        s1_fault    <= op_fault;
    end

    assign lane_byte = mem.rdata[{s1_offset, 3'b000} +: 8];
    assign lane_half = s1_offset[1] ? mem.rdata[31:16] : mem.rdata[15:0];

    always_comb
    begin
        case (s1_size)
            2'b00:
                extended = s1_unsigned ? {24'b0, lane_byte} : {{24{lane_byte[7]}}, lane_byte};
            2'b01:
                extended = s1_unsigned ? {16'b0, lane_half} : {{16{lane_half[15]}}, lane_half};
            default:
                extended = mem.rdata;
        endcase
    end

    // Stage 2, result registers
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            done  <= 1'b0;
            fault <= 1'b0;
        end
        else
        begin
            done  <= s1_valid;
            fault <= s1_valid & s1_fault;
        end

        load_data <= (s1_valid && s1_load && !s1_fault) ? extended : '0;
    end

endmodule

`default_nettype wire

// ==== logic/data_memory.sv ====
`timescale 1ns/1ps
`include "lsu_config.svh"
`default_nettype none

module data_memory
    import lsu_pkg::*;
(
    input  wire      clk,
    mem_if.responder mem
);
    localparam int DEPTH = 1 << `LSU_DMEM_ADDR_BITS;

    word_t                          mem_array [DEPTH];
    logic [`LSU_DMEM_ADDR_BITS-1:0] word_index;

    // Word index, byte offset dropped
    assign word_index = mem.addr[`LSU_DMEM_ADDR_BITS+1:2];

    always_ff @(posedge clk)
    begin
        if (mem.en)
        begin
            if (mem.we)
            begin
                // Only enabled lanes change
                for (int k = 0; k < 4; k++)
                begin
                    if (mem.be[k])
                        mem_array[word_index][8*k +: 8] <= mem.wdata[8*k +: 8];
                end
            end
            else
            begin
                mem.rdata <= mem_array[word_index];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         valid,
    input  wire instr_u instr,
    input  wire word_t  rs1_value,
    input  wire word_t  rs2_value,
    output wire         done,
    output wire         fault,
    output wire word_t  load_data
);
    logic   op_valid;
    logic   op_store;
    width_t op_width;
    word_t  op_addr;
    word_t  op_wdata;

    mem_if mem_bus ();

    address_gen agen0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid     (valid),
        .instr     (instr),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .op_valid  (op_valid),
        .op_store  (op_store),
        .op_width  (op_width),
        .op_addr   (op_addr),
        .op_wdata  (op_wdata)
    );

    load_store_unit lsu0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_valid  (op_valid),
        .op_store  (op_store),
        .op_width  (op_width),
        .op_addr   (op_addr),
        .op_wdata  (op_wdata),
        .mem       (mem_bus.requester),
        .done      (done),
        .fault     (fault),
        .load_data (load_data)
    );

    data_memory dmem0 (
        .clk (clk),
        .mem (mem_bus.responder)
    );

endmodule

`default_nettype wire

// ==== testbench/lsu_props.sv ====
`timescale 1ns/1ps
`include "lsu_config.svh"
`default_nettype none

module lsu_props
    import lsu_pkg::*;
(
    input wire        clk,
    input wire        rst_n,
    input wire        valid,
    input wire [6:0]  opcode,
    input wire        mem_en,
    input wire        mem_we,
    input wire mask_t mem_be,
    input wire        done,
    input wire        fault
);
    logic mem_op;

    assign mem_op = valid && (opcode == `LSU_OP_LOAD || opcode == `LSU_OP_STORE);

    write_has_lanes: assert property (
        @(posedge clk) disable iff (!rst_n) (mem_en && mem_we) |-> (mem_be != 4'b0000))
        else $error("memory write with an empty byte mask");

    fault_with_done: assert property (@(posedge clk) disable iff (!rst_n) fault |-> done)
        else $error("fault raised without done");

    // Synchronous reset, done clears one edge later
    quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !done)
        else $error("done high during reset");

    done_after_issue: assert property (@(posedge clk) disable iff (!rst_n) mem_op |-> ##3 done)
        else $error("load or store without done three cycles later");

endmodule

bind lsu_top lsu_props props0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .valid  (valid),
    .opcode (instr.i_fmt.opcode),
    .mem_en (mem_bus.en),
    .mem_we (mem_bus.we),
    .mem_be (mem_bus.be),
    .done   (done),
    .fault  (fault)
);

`default_nettype wire

// ==== testbench/lsu_tb.sv ====
`timescale 1ns/1ps
`include "lsu_config.svh"
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();
    localparam int MODEL_BYTES = 4 << `LSU_DMEM_ADDR_BITS;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       valid;
    instr_u     instr;
    word_t      rs1_value;
    word_t      rs2_value;
    logic       done;
    logic       fault;
    word_t      load_data;

    logic [7:0] model_mem [MODEL_BYTES];
    word_t      lfsr_state = 32'he8512bf1;
    int         cycle = 0;
    int         checks = 0;
    int         errors = 0;
    int         exp_cycle [$];
    logic       exp_fault [$];
    word_t      exp_data [$];

    lsu_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid     (valid),
        .instr     (instr),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .done      (done),
        .fault     (fault),
        .load_data (load_data)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic word_t rand_bits(input int n);
        word_t v;
        logic  b;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            // Galois step, one per bit
            b = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (b ? 32'ha300_0000 : 32'h0);
            v = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic word_t fill_pattern(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]};
    endfunction

    function automatic instr_u make_instr(input logic store, input width_t w,
                                          input logic [11:0] imm);
        instr_u ins;
        if (store)
            ins.s_fmt = '{imm[11:5], 5'd2, 5'd1, w, imm[4:0], `LSU_OP_STORE};
        else
            ins.i_fmt = '{imm, 5'd1, w, 5'd3, `LSU_OP_LOAD};
        return ins;
    endfunction

    // Byte-array memory, little-endian lanes
    task automatic model_access(input logic store, input width_t w, input word_t addr,
                                input word_t wdata, output logic f, output word_t data);
        int    size;
        int    base;
        word_t raw;
        size = (w == WIDTH_WORD) ? 4 : ((w == WIDTH_HALF || w == WIDTH_HALF_U) ? 2 : 1);
        base = int'(addr[`LSU_DMEM_ADDR_BITS+1:0]);
        f    = (addr & word_t'(size - 1)) != 0;
        raw  = '0;
        data = '0;
        if (!f)
        begin
            for (int k = 0; k < size; k++)
            begin
                if (store)
                    model_mem[base + k] = wdata[8*k +: 8];
                else
                    raw[8*k +: 8] = model_mem[base + k];
            end
            case (w)
                WIDTH_BYTE: data = {{24{raw[7]}}, raw[7:0]};
                WIDTH_HALF: data = {{16{raw[15]}}, raw[15:0]};
                default:    data = raw;
            endcase
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("Fail %0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("Fail %0t %s got %b expected %b", $time, name, got, expected);
        end
    endtask

    task automatic note_error(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // One clock, outputs checked before new inputs go out
    task automatic step(input logic v, input instr_u ins, input word_t r1, input word_t r2);
        @(posedge clk);
        #1;
        cycle++;
        if (done === 1'b1)
        begin
            if (exp_cycle.size() == 0)
                note_error("done raised with no operation outstanding");
            else
            begin
                if (exp_cycle[0] != cycle)
                    note_error($sformatf("done due at cycle %0d came at cycle %0d",
                                         exp_cycle[0], cycle));
                check_flag("fault", fault, exp_fault.pop_front());
                check_word("load_data", load_data, exp_data.pop_front());
                void'(exp_cycle.pop_front());
            end
        end
        else
        begin
            check_flag("done", done, 1'b0);
            check_flag("fault", fault, 1'b0);
            if (exp_cycle.size() > 0 && exp_cycle[0] <= cycle)
            begin
                note_error($sformatf("done missing at cycle %0d", cycle));
                void'(exp_cycle.pop_front());
                void'(exp_fault.pop_front());
                void'(exp_data.pop_front());
            end
        end
        valid     = v;
        instr     = ins;
        rs1_value = r1;
        rs2_value = r2;
    endtask

    task automatic idle();
        step(1'b0, '0, '0, '0);
    endtask

    task automatic issue(input logic store, input width_t w, input word_t base,
                         input logic [11:0] imm, input word_t wdata);
        logic  f;
        word_t data;
        model_access(store, w, base + {{20{imm[11]}}, imm}, wdata, f, data);
        step(1'b1, make_instr(store, w, imm), base, wdata);
        exp_cycle.push_back(cycle + 3);
        exp_fault.push_back(f);
        exp_data.push_back(data);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_cycle.size() > 0 && waited < 10)
        begin
            idle();
            waited++;
        end
        if (exp_cycle.size() > 0)
        begin
            note_error("timed out waiting for done");
            exp_cycle.delete();
            exp_fault.delete();
            exp_data.delete();
        end
    endtask

    task automatic report_test(input string name, input int mark);
        $display("%-16s %s, %0d errors", name, (errors == mark) ? "passed" : "failed",
                 errors - mark);
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic test_reset_and_words();
        word_t       bases [4];
        logic [11:0] offsets [4];
        bases   = '{32'h0000_0200, 32'h0000_0210, 32'h0000_03fc, 32'h0000_0080};
        offsets = '{12'h010, 12'hff0, 12'h7fc, 12'h800};
        repeat (5) idle();
        // Known contents in every word
        for (int i = 0; i < MODEL_BYTES / 4; i++)
            issue(1'b1, WIDTH_WORD, word_t'(i * 4), 12'd0, fill_pattern(word_t'(i * 4)));
        drain();
        for (int i = 0; i < 4; i++)
        begin
            issue(1'b1, WIDTH_WORD, bases[i], offsets[i], rand_bits(32));
            drain();
            issue(1'b0, WIDTH_WORD, bases[i], offsets[i], '0);
            drain();
        end
    endtask

    task automatic test_sub_word();
        word_t base;
        word_t wdata;
        base = 32'h0000_0140;
        for (int k = 0; k < 4; k++)
        begin
            wdata    = rand_bits(32);
            wdata[7] = k[0];
            issue(1'b1, WIDTH_BYTE, base, 12'(k), wdata);
            issue(1'b0, WIDTH_WORD, base, 12'd0, '0);
            issue(1'b0, WIDTH_BYTE, base, 12'(k), '0);
            issue(1'b0, WIDTH_BYTE_U, base, 12'(k), '0);
            drain();
        end
        for (int k = 0; k < 4; k += 2)
        begin
            wdata     = rand_bits(32);
            wdata[15] = ~k[1];
            issue(1'b1, WIDTH_HALF, base, 12'(k), wdata);
            issue(1'b0, WIDTH_WORD, base, 12'd0, '0);
            issue(1'b0, WIDTH_HALF, base, 12'(k), '0);
            issue(1'b0, WIDTH_HALF_U, base, 12'(k), '0);
            drain();
        end
    endtask

    task automatic test_misaligned();
        word_t base;
        base = 32'h0000_0300;
        for (int k = 1; k < 4; k++)
        begin
            if (k != 2)
            begin
                issue(1'b0, WIDTH_HALF, base, 12'(k), '0);
                issue(1'b0, WIDTH_HALF_U, base, 12'(k), '0);
                issue(1'b1, WIDTH_HALF, base, 12'(k), rand_bits(32));
            end
            issue(1'b0, WIDTH_WORD, base, 12'(k), '0);
            issue(1'b1, WIDTH_WORD, base, 12'(k), rand_bits(32));
            // Word still holds its old value
            issue(1'b0, WIDTH_WORD, base, 12'd0, '0);
            drain();
        end
    endtask

    task automatic test_other_opcodes();
        logic [6:0] opcodes [3];
        instr_u     ins;
        opcodes = '{7'b0010011, 7'b0110011, 7'b1100011};
        for (int j = 0; j < 3; j++)
        begin
            ins = make_instr(1'b0, WIDTH_WORD, 12'h004);
            ins.i_fmt.opcode = opcodes[j];
            step(1'b1, ins, 32'h0000_0100, 32'h1234_5678);
            repeat (10) idle();
        end
    endtask

    task automatic test_back_to_back();
        width_t      load_widths [5];
        width_t      store_widths [3];
        logic        store;
        width_t      w;
        word_t       addr;
        logic [11:0] imm;
        load_widths  = '{WIDTH_BYTE, WIDTH_HALF, WIDTH_WORD, WIDTH_BYTE_U, WIDTH_HALF_U};
        store_widths = '{WIDTH_BYTE, WIDTH_HALF, WIDTH_WORD};
        w     = WIDTH_WORD;
        addr  = '0;
        store = 1'b0;
        for (int i = 0; i < 64; i++)
        begin
            // A store at i%4==0 is read back on the very next cycle
            if (i % 4 == 1)
                store = 1'b0;
            else
            begin
                store = (i % 4 == 0) || (rand_bits(1) == 1);
                w     = store ? store_widths[rand_bits(2) % 3] : load_widths[rand_bits(3) % 5];
                addr  = rand_bits(32);
                if (rand_bits(2) != 0)
                    addr[1:0] = 2'b00;
            end
            imm = 12'(rand_bits(12));
            issue(store, w, addr - {{20{imm[11]}}, imm}, imm, rand_bits(32));
        end
        drain();
    endtask

    initial
    begin
        int mark;
        rst_n     = 1'b0;
        valid     = 1'b0;
        instr     = '0;
        rs1_value = '0;
        rs2_value = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        mark = errors;
        test_reset_and_words();
        report_test("reset_and_words", mark);
        mark = errors;
        test_sub_word();
        report_test("sub_word", mark);
        mark = errors;
        test_misaligned();
        report_test("misaligned", mark);
        mark = errors;
        test_other_opcodes();
        report_test("other_opcodes", mark);
        mark = errors;
        test_back_to_back();
        report_test("back_to_back", mark);
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+logic
logic/lsu_pkg.sv
logic/mem_if.sv
logic/address_gen.sv
logic/load_store_unit.sv
logic/data_memory.sv
logic/lsu_top.sv
testbench/lsu_props.sv
testbench/lsu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lsu_tb -f compile.f -o lsu_sim

status=0
./obj_dir/lsu_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation passed"
